//--- dv/csr_top_asserts.sv
`timescale 1ns/1ps

module csr_top_asserts (
    input logic                           clk,
    input logic                           rst_n_i,
    input logic                           psel_i,
    input logic                           penable_i,
    input logic                           pwrite_i,
    input logic [csr_pkg::CSR_ADDR_W-1:0] paddr_i,
    input logic [csr_pkg::CSR_DATA_W-1:0] pwdata_i,
    input logic                           pready_i,
    input logic                           pslverr_i,
    input logic                           irq_i
);

    import csr_pkg::*;

    int   fail_cnt;
    logic ie_q;    // CRMD IE as last written on the bus
    logic mapped;

    // CRMD takes the write in the first access cycle
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ie_q <= 1'b0;
        end else if (psel_i && penable_i && !pready_i && pwrite_i &&
                     (paddr_i == CSR_CRMD)) begin
            ie_q <= pwdata_i[CRMD_IE_BIT];
        end
    end

    assign mapped = paddr_i inside {CSR_CRMD, CSR_ECFG, CSR_ESTAT, CSR_TID, CSR_TCFG,
                                    CSR_TVAL, CSR_TICLR, CSR_CNTL, CSR_CNTH};

    a_ready_in_access: assert property (@(posedge clk) disable iff (!rst_n_i)
        pready_i |-> psel_i && penable_i)
    else begin
        $error("pready_o high outside an APB access phase");
        fail_cnt++;
    end

    // Second access cycle, never the first
    a_ready_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(penable_i) |-> !pready_i ##1 pready_i)
    else begin
        $error("pready_o not in the second access cycle");
        fail_cnt++;
    end

    a_err_with_ready: assert property (@(posedge clk) disable iff (!rst_n_i)
        pslverr_i |-> pready_i && !mapped)
    else begin
        $error("pslverr_o high without pready_o or for a mapped CSR");
        fail_cnt++;
    end

    a_irq_needs_ie: assert property (@(posedge clk) disable iff (!rst_n_i)
        irq_i |-> ie_q)
    else begin
        $error("irq_o high while CRMD IE is clear");
        fail_cnt++;
    end

endmodule

bind csr_top csr_top_asserts u_asserts (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pready_i  (pready_o),
    .pslverr_i (pslverr_o),
    .irq_i     (irq_o)
);

//--- dv/tb_csr_top.sv
`timescale 1ns/1ps

module tb_csr_top;

    import csr_pkg::*;

    localparam int TIMEOUT_CYCLES = 20000; // Tests need a few thousand cycles
    localparam int TMR_N          = 16;    // TCFG initval in the timer tests

    logic                  clk;
    logic                  rst_n_i;
    logic                  psel_i;
    logic                  penable_i;
    logic                  pwrite_i;
    logic [CSR_ADDR_W-1:0] paddr_i;
    logic [CSR_DATA_W-1:0] pwdata_i;
    logic [CSR_DATA_W-1:0] prdata_o;
    logic                  pready_o;
    logic                  pslverr_o;
    logic [INT_HW_NUM-1:0] intrpt_i;
    logic                  irq_o;

    // Last written values, unmasked
    logic [CSR_DATA_W-1:0] sh_crmd;
    logic [CSR_DATA_W-1:0] sh_ecfg;
    logic [CSR_DATA_W-1:0] sh_estat;
    logic [CSR_DATA_W-1:0] sh_tid;
    logic [CSR_DATA_W-1:0] sh_tcfg;

    logic [CSR_ADDR_W-1:0] rw_addr [5];
    integer                seed;
    int                    cycles;
    string                 test_name;

    csr_top i_dut (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .psel_i    (psel_i),
        .penable_i (penable_i),
        .pwrite_i  (pwrite_i),
        .paddr_i   (paddr_i),
        .pwdata_i  (pwdata_i),
        .prdata_o  (prdata_o),
        .pready_o  (pready_o),
        .pslverr_o (pslverr_o),
        .intrpt_i  (intrpt_i),
        .irq_o     (irq_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Finished with errors");
            $fatal(1, "Simulation stopped by the cycle limit");
        end
    end

    // First failed assertion in the bound checker ends the run
    always @(i_dut.u_asserts.fail_cnt) begin
        if (i_dut.u_asserts.fail_cnt != 0) begin
            $display("A bound assertion failed in test %s", test_name);
            $display("Finished with errors");
            $fatal(1, "Stopping at the first assertion failure");
        end
    end

    task automatic check_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
        if (exp !== act) begin
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Expected read word, MSB is the expected slave error
    function automatic logic [CSR_DATA_W:0] ref_read(input logic [CSR_ADDR_W-1:0] addr);
        logic [CSR_DATA_W-1:0] estat;
        estat = (sh_estat & ESTAT_SW_MASK) | (CSR_DATA_W'(intrpt_i) << INT_HW_LSB);
        case (addr)
            CSR_CRMD:  return {1'b0, sh_crmd & CRMD_MASK};
            CSR_ECFG:  return {1'b0, sh_ecfg & ECFG_MASK};
            CSR_ESTAT: return {1'b0, estat};  // Timer bit not modelled
            CSR_TID:   return {1'b0, sh_tid};
            CSR_TCFG:  return {1'b0, sh_tcfg};
            CSR_TVAL, CSR_TICLR, CSR_CNTL, CSR_CNTH: return {1'b0, 32'h0};
            default:   return {1'b1, 32'h0};
        endcase
    endfunction

    // Checks each completed transfer against the reference
    always @(posedge clk) begin
        logic [CSR_DATA_W:0] exp_w;
        if (psel_i && penable_i && pready_o) begin
            exp_w = ref_read(paddr_i);
            check_value(test_name, exp_w[CSR_DATA_W], pslverr_o);
            if (!pwrite_i) begin
                case (paddr_i)
                    CSR_TVAL, CSR_CNTL, CSR_CNTH: ; // Timer rules checked in the tests
                    CSR_ESTAT: check_value(test_name, exp_w[CSR_DATA_W-1:0],
                                           prdata_o & ~(32'h1 << INT_TI_BIT));
                    default: check_value(test_name, exp_w[CSR_DATA_W-1:0], prdata_o);
                endcase
            end
        end
    end

    // Setup cycle, then access cycles until pready_o
    task automatic apb_transfer(input logic wr, input logic [CSR_ADDR_W-1:0] addr,
                                input logic [CSR_DATA_W-1:0] wdata,
                                output logic [CSR_DATA_W-1:0] rdata);
        int waits;
        waits     = 0;
        psel_i    = 1'b1;
        penable_i = 1'b0;
        pwrite_i  = wr;
        paddr_i   = addr;
        pwdata_i  = wdata;
        @(posedge clk);
        #1;
        penable_i = 1'b1;
        do begin
            @(posedge clk);
            #1;
            waits++;
        end while (!pready_o);
        check_value("pready_o in the second access cycle", 1, waits);
        rdata = prdata_o;
        @(posedge clk);
        #1;
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic apb_write(input logic [CSR_ADDR_W-1:0] addr,
                             input logic [CSR_DATA_W-1:0] data);
        logic [CSR_DATA_W-1:0] unused;
        apb_transfer(1'b1, addr, data, unused);
        case (addr)
            CSR_CRMD:  sh_crmd  = data;
            CSR_ECFG:  sh_ecfg  = data;
            CSR_ESTAT: sh_estat = data;
            CSR_TID:   sh_tid   = data;
            CSR_TCFG:  sh_tcfg  = data;
            default: ;
        endcase
    endtask

    task automatic apb_read(input logic [CSR_ADDR_W-1:0] addr,
                            output logic [CSR_DATA_W-1:0] data);
        apb_transfer(1'b0, addr, '0, data);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    initial begin
        logic [CSR_DATA_W-1:0] rd;
        logic [CSR_DATA_W-1:0] v0;
        logic [CSR_DATA_W-1:0] v1;
        logic [CSR_DATA_W:0]   exp_estat;
        logic                  exp_irq;
        int                    idx;
        seed      = 32'h068192bb;
        rst_n_i   = 1'b0;
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
        paddr_i   = '0;
        pwdata_i  = '0;
        intrpt_i  = '0;
        sh_crmd   = '0;
        sh_ecfg   = '0;
        sh_estat  = '0;
        sh_tid    = '0;
        sh_tcfg   = '0;
        rw_addr   = '{CSR_CRMD, CSR_ECFG, CSR_ESTAT, CSR_TID, CSR_TCFG};
        test_name = "reset";
        repeat (4) @(posedge clk);
        #1;
        rst_n_i = 1'b1;

        test_name = "register write and read";
        repeat (200) begin
            idx = $unsigned($random(seed)) % 5;
            apb_write(rw_addr[idx], $random(seed));
            apb_read(rw_addr[idx], rd);
        end
        apb_write(14'h003, $random(seed)); // No CSR at this number
        apb_read(14'h003, rd);
        foreach (rw_addr[i]) apb_read(rw_addr[i], rd);

        test_name = "stable counter";
        apb_read(CSR_CNTL, v0);
        apb_read(CSR_CNTH, v1);
        repeat (3) begin
            apb_read(CSR_CNTH, rd);
            check_value(test_name, v1, rd);
        end
        apb_read(CSR_CNTL, rd);
        check_value(test_name, v0 + 3 * 5, rd); // Five transfers of 3 cycles

        test_name = "one-shot timer";
        apb_write(CSR_CRMD, 32'h4);
        apb_write(CSR_ECFG, 32'h1 << INT_TI_BIT);
        apb_write(CSR_TCFG, (TMR_N << 2) | 32'h1);
        apb_write(CSR_TICLR, 32'h1);
        apb_read(CSR_TVAL, v0);
        repeat (3) begin
            apb_read(CSR_TVAL, rd);
            check_value(test_name, 1, rd < v0);
            v0 = rd;
        end
        idle_cycles(4 * TMR_N);
        apb_read(CSR_ESTAT, rd);
        check_value(test_name, 1, rd[INT_TI_BIT]);
        check_value(test_name, 1, irq_o);
        apb_write(CSR_TICLR, 32'h1);
        idle_cycles(4 * TMR_N);
        apb_read(CSR_ESTAT, rd);
        check_value(test_name, 0, rd[INT_TI_BIT]);
        check_value(test_name, 0, irq_o);

        test_name = "periodic timer";
        apb_write(CSR_TCFG, (TMR_N << 2) | 32'h3);
        apb_write(CSR_TICLR, 32'h1);
        idle_cycles(4 * TMR_N);
        apb_read(CSR_ESTAT, rd);
        check_value(test_name, 1, rd[INT_TI_BIT]);
        apb_write(CSR_TICLR, 32'h1);
        repeat (2 * TMR_N) begin   // Spans more than one period
            apb_read(CSR_TVAL, rd);
            check_value(test_name, 1, rd != 0);
        end
        apb_read(CSR_ESTAT, rd);
        check_value(test_name, 1, rd[INT_TI_BIT]);
        apb_write(CSR_TCFG, 32'h0);
        apb_write(CSR_TICLR, 32'h1);

        test_name = "external and software interrupts";
        repeat (100) begin
            intrpt_i = $random(seed);
            apb_write(CSR_ESTAT, $random(seed));
            apb_write(CSR_ECFG, $random(seed));
            apb_write(CSR_CRMD, $random(seed));
            apb_read(CSR_ESTAT, rd);
            check_value(test_name, intrpt_i, rd[INT_HW_LSB +: INT_HW_NUM]);
            exp_estat = ref_read(CSR_ESTAT);
            exp_irq   = sh_crmd[CRMD_IE_BIT] &&
                        |(exp_estat[INT_NUM-1:0] & sh_ecfg[INT_NUM-1:0]);
            check_value(test_name, exp_irq, irq_o);
        end

        $display("Finished with no errors");
        $finish;
    end

endmodule

//--- filelist.f
rtl/csr_pkg.sv
rtl/apb_slave_fsm.sv
rtl/csr_timer.sv
rtl/csr_bank.sv
rtl/csr_top.sv
dv/csr_top_asserts.sv
dv/tb_csr_top.sv

//--- rtl/apb_slave_fsm.sv
`timescale 1ns/1ps

module apb_slave_fsm (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] paddr_i,
    input  logic [csr_pkg::CSR_DATA_W-1:0] rd_data_i,
    input  logic                           addr_hit_i,
    output logic                           csr_wr_o,
    output logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_o,
    output logic [csr_pkg::CSR_DATA_W-1:0] prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o
);

    import csr_pkg::*;

    logic [1:0]            state_q;
    logic [1:0]            state_d;
    logic [CSR_DATA_W-1:0] rdata_q;
    logic                  err_q;

    // Setup, one access cycle for the CSR, one for the response
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (psel_i && !penable_i) begin
                    state_d = ST_WAIT;
                end
            end
            ST_WAIT: state_d = ST_RESP;
            ST_RESP: state_d = ST_IDLE;
            default: state_d = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
            err_q   <= 1'b0;
            rdata_q <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ST_WAIT) begin
                err_q   <= ~addr_hit_i; // Unmapped CSR number
                // Read word sampled while the address is decoded
                rdata_q <= pwrite_i ? '0 : rd_data_i;
            end
        end
    end

    assign csr_addr_o = paddr_i;
    assign csr_wr_o   = (state_q == ST_WAIT) && pwrite_i && addr_hit_i;
    assign pready_o   = (state_q == ST_RESP);
    assign pslverr_o  = (state_q == ST_RESP) && err_q;
    assign prdata_o   = rdata_q;

endmodule

//--- rtl/csr_bank.sv
`timescale 1ns/1ps

module csr_bank (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           csr_wr_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] csr_addr_i,
    input  logic [csr_pkg::CSR_DATA_W-1:0] wdata_i,
    input  logic [csr_pkg::INT_HW_NUM-1:0] intrpt_i,
    input  logic [csr_pkg::TIMER_W-1:0]    tval_i,
    input  logic                           timer_int_i,
    input  logic [csr_pkg::CNT_W-1:0]      stable_cnt_i,
    output logic [csr_pkg::CSR_DATA_W-1:0] rd_data_o,
    output logic                           addr_hit_o,
    output logic                           tcfg_wr_o,
    output csr_pkg::tcfg_u                 tcfg_o,
    output logic                           ticlr_clr_o,
    output logic                           irq_o
);

    import csr_pkg::*;

    logic [CSR_DATA_W-1:0] crmd_q;
    logic [CSR_DATA_W-1:0] ecfg_q;
    logic [CSR_DATA_W-1:0] estat_sw_q;
    logic [CSR_DATA_W-1:0] tid_q;
    tcfg_u                 tcfg_q;
    logic [INT_HW_NUM-1:0] intrpt_q;
    logic                  tcfg_wr_q;
    logic [CSR_DATA_W-1:0] estat;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            crmd_q     <= '0;
            ecfg_q     <= '0;
            estat_sw_q <= '0;
            tid_q      <= '0;
            tcfg_q     <= '0;
            intrpt_q   <= '0;
            tcfg_wr_q  <= 1'b0;
        end else begin
            intrpt_q  <= intrpt_i; // External lines sampled every cycle
            tcfg_wr_q <= csr_wr_i && (csr_addr_i == CSR_TCFG);
            if (csr_wr_i) begin
                case (csr_addr_i)
                    CSR_CRMD:  crmd_q     <= wdata_i & CRMD_MASK; // PLV is storage only
                    CSR_ECFG:  ecfg_q     <= wdata_i & ECFG_MASK;
                    CSR_ESTAT: estat_sw_q <= wdata_i & ESTAT_SW_MASK;
                    CSR_TID:   tid_q      <= wdata_i;
                    CSR_TCFG:  tcfg_q.raw <= wdata_i;
                    default: ;  // TVAL and counter windows are read-only
                endcase
            end
        end
    end

    // ESTAT view: software bits, sampled lines, timer flag
    always_comb begin
        estat                                = estat_sw_q;
        estat[INT_HW_LSB +: INT_HW_NUM]      = intrpt_q;
        estat[INT_TI_BIT]                    = timer_int_i;
    end

    always_comb begin
        rd_data_o  = '0;
        addr_hit_o = 1'b1;
        case (csr_addr_i)
            CSR_CRMD:  rd_data_o = crmd_q;
            CSR_ECFG:  rd_data_o = ecfg_q;
            CSR_ESTAT: rd_data_o = estat;
            CSR_TID:   rd_data_o = tid_q;
            CSR_TCFG:  rd_data_o = tcfg_q.raw;
            CSR_TVAL:  rd_data_o = tval_i;
            CSR_TICLR: rd_data_o = '0;
            CSR_CNTL:  rd_data_o = stable_cnt_i[CSR_DATA_W-1:0];
            CSR_CNTH:  rd_data_o = stable_cnt_i[CNT_W-1:CSR_DATA_W];
            default:   addr_hit_o = 1'b0;
        endcase
    end

    // Bit 0 of a TICLR write clears the timer flag
    assign ticlr_clr_o = csr_wr_i && (csr_addr_i == CSR_TICLR) && wdata_i[0];

    // Timer reloads once the new TCFG is visible
    assign tcfg_wr_o = tcfg_wr_q;
    assign tcfg_o    = tcfg_q;

    assign irq_o = crmd_q[CRMD_IE_BIT] && |(estat[INT_NUM-1:0] & ecfg_q[INT_NUM-1:0]);

endmodule

//--- rtl/csr_pkg.sv
package csr_pkg;

    localparam int CSR_ADDR_W = 14;
    localparam int CSR_DATA_W = 32;
    localparam int TIMER_W    = 32;
    localparam int CNT_W      = 64;

    // Architectural CSR numbers
    localparam logic [CSR_ADDR_W-1:0] CSR_CRMD  = 14'h000;
    localparam logic [CSR_ADDR_W-1:0] CSR_ECFG  = 14'h004;
    localparam logic [CSR_ADDR_W-1:0] CSR_ESTAT = 14'h005;
    localparam logic [CSR_ADDR_W-1:0] CSR_TID   = 14'h040;
    localparam logic [CSR_ADDR_W-1:0] CSR_TCFG  = 14'h041;
    localparam logic [CSR_ADDR_W-1:0] CSR_TVAL  = 14'h042;
    localparam logic [CSR_ADDR_W-1:0] CSR_TICLR = 14'h044;
    localparam logic [CSR_ADDR_W-1:0] CSR_CNTL  = 14'h100; // Stable counter, low word
    localparam logic [CSR_ADDR_W-1:0] CSR_CNTH  = 14'h101; // Stable counter, high word

    // Writable bits
    localparam logic [CSR_DATA_W-1:0] CRMD_MASK     = 32'h0000_0007; // PLV and IE
    localparam logic [CSR_DATA_W-1:0] ECFG_MASK     = 32'h0000_1fff; // LIE
    localparam logic [CSR_DATA_W-1:0] ESTAT_SW_MASK = 32'h0000_0003; // Software interrupts

    localparam int CRMD_IE_BIT = 2;

    // Interrupt layout in ESTAT and ECFG
    localparam int INT_HW_LSB = 2;
    localparam int INT_HW_NUM = 8;
    localparam int INT_TI_BIT = 11;
    localparam int INT_NUM    = 13;

    // APB slave FSM states
    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_WAIT = 2'd1;
    localparam logic [1:0] ST_RESP = 2'd2;

    typedef struct packed {
        logic [29:0] initval;  // Load value without its two low zero bits
        logic        periodic;
        logic        en;
    } tcfg_fields_t;

    // TCFG seen as the CSR word or as the timer fields
    typedef union packed {
        logic [CSR_DATA_W-1:0] raw;
        tcfg_fields_t          f;
    } tcfg_u;

endpackage

//--- rtl/csr_timer.sv
`timescale 1ns/1ps

module csr_timer (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        tcfg_wr_i,
    input  csr_pkg::tcfg_u              tcfg_i,
    input  logic                        ticlr_clr_i,
    output logic [csr_pkg::TIMER_W-1:0] tval_o,
    output logic                        timer_int_o,
    output logic [csr_pkg::CNT_W-1:0]   stable_cnt_o
);

    import csr_pkg::*;

    logic [CNT_W-1:0]   cnt_q;
    logic [TIMER_W-1:0] tval_q;
    logic [TIMER_W-1:0] load_val;
    logic               int_q;
    logic               expire;

    assign load_val = {tcfg_i.f.initval, 2'b00};

    // Step from 1 to 0, unless a new configuration is loading
    assign expire = !tcfg_wr_i && tcfg_i.f.en && (tval_q == TIMER_W'(1));

    // Free-running stable counter
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            tval_q <= '0;
        end else if (tcfg_wr_i) begin
            tval_q <= load_val;
        end else if (tcfg_i.f.en && (tval_q != '0)) begin
            if (expire && tcfg_i.f.periodic) begin
                tval_q <= load_val; // Periodic mode never rests at 0
            end else begin
                tval_q <= tval_q - 1'b1;
            end
        end
    end

    // Timer interrupt flag, a new expiry beats the clear
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            int_q <= 1'b0;
        end else if (expire) begin
            int_q <= 1'b1;
        end else if (ticlr_clr_i) begin
            int_q <= 1'b0;
        end
    end

    assign tval_o       = tval_q;
    assign timer_int_o  = int_q;
    assign stable_cnt_o = cnt_q;

endmodule

//--- rtl/csr_top.sv
`timescale 1ns/1ps

module csr_top (
    input  logic                           clk,
    input  logic                           rst_n_i,
    input  logic                           psel_i,
    input  logic                           penable_i,
    input  logic                           pwrite_i,
    input  logic [csr_pkg::CSR_ADDR_W-1:0] paddr_i,
    input  logic [csr_pkg::CSR_DATA_W-1:0] pwdata_i,
    output logic [csr_pkg::CSR_DATA_W-1:0] prdata_o,
    output logic                           pready_o,
    output logic                           pslverr_o,
    input  logic [csr_pkg::INT_HW_NUM-1:0] intrpt_i,
    output logic                           irq_o
);

    import csr_pkg::*;

    // APB FSM <-> register bank
    logic                  csr_wr;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic [CSR_DATA_W-1:0] rd_data;
    logic                  addr_hit;

    // Register bank <-> timer
    logic                  tcfg_wr;
    tcfg_u                 tcfg;
    logic                  ticlr_clr;
    logic [TIMER_W-1:0]    tval;
    logic                  timer_int;
    logic [CNT_W-1:0]      stable_cnt;

    apb_slave_fsm u_apb_fsm (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .psel_i     (psel_i),
        .penable_i  (penable_i),
        .pwrite_i   (pwrite_i),
        .paddr_i    (paddr_i),
        .rd_data_i  (rd_data),
        .addr_hit_i (addr_hit),
        .csr_wr_o   (csr_wr),
        .csr_addr_o (csr_addr),
        .prdata_o   (prdata_o),
        .pready_o   (pready_o),
        .pslverr_o  (pslverr_o)
    );

    csr_bank u_bank (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .csr_wr_i     (csr_wr),
        .csr_addr_i   (csr_addr),
        .wdata_i      (pwdata_i),   // Held by the master through the access
        .intrpt_i     (intrpt_i),
        .tval_i       (tval),
        .timer_int_i  (timer_int),
        .stable_cnt_i (stable_cnt),
        .rd_data_o    (rd_data),
        .addr_hit_o   (addr_hit),
        .tcfg_wr_o    (tcfg_wr),
        .tcfg_o       (tcfg),
        .ticlr_clr_o  (ticlr_clr),
        .irq_o        (irq_o)
    );

    csr_timer u_timer (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .tcfg_wr_i    (tcfg_wr),
        .tcfg_i       (tcfg),
        .ticlr_clr_i  (ticlr_clr),
        .tval_o       (tval),
        .timer_int_o  (timer_int),
        .stable_cnt_o (stable_cnt)
    );

endmodule
